// ==== verilog/mfifoPkg.sv ====
`default_nettype none

// Geometry of the logical FIFOs that share the data RAM
package mfifoPkg;

  // Number of logical FIFOs carved out of the shared RAM
  localparam int NumFifos = 4;

  // Width of one data word on the push and pop sides
  localparam int Width = 8;

  // Binary FIFO ID on the push side selects one of NumFifos
  localparam int FifoIdWidth = 2;

  // Each pop port is served from a small staging buffer of this depth
  localparam int StagingDepth = 2;

  // Occupancy and reservation counters in a staging buffer must reach StagingDepth
  localparam int StagingCntWidth = 2;

endpackage : mfifoPkg

`default_nettype wire

// ==== verilog/ramPkg.sv ====
`default_nettype none

// Shape and timing of the shared data RAM
package ramPkg;

  // Total entries shared by all logical FIFOs
  localparam int Depth = 16;

  localparam int AddrWidth = 4;

  // A per-FIFO occupancy count has to hold the value Depth itself
  localparam int CountWidth = 5;

  // Cycles from a read address to its read data
  localparam int ReadLatency = 1;

endpackage : ramPkg

`default_nettype wire

// ==== verilog/ramIf.sv ====
`timescale 1ns/1ps
`default_nettype none

// Write and read ports of the shared data RAM
// Neither port has back-pressure, so an access happens whenever its valid is high
interface ramIf;

  // Write port
  logic                          wrValid;
  logic [ramPkg::AddrWidth-1:0]  wrAddr;
  logic [mfifoPkg::Width-1:0]    wrData;

  // Read address, issued by the controller
  logic                          rdAddrValid;
  logic [ramPkg::AddrWidth-1:0]  rdAddr;

  // Read data, returned ReadLatency cycles after the address
  logic                          rdDataValid;
  logic [mfifoPkg::Width-1:0]    rdData;

  // The controller drives both addresses and takes back the read data
  modport ctrl (
    output wrValid, wrAddr, wrData, rdAddrValid, rdAddr,
    input  rdDataValid, rdData
  );

  // The memory side is the mirror image
  modport mem (
    input  wrValid, wrAddr, wrData, rdAddrValid, rdAddr,
    output rdDataValid, rdData
  );

endinterface : ramIf

`default_nettype wire

// ==== verilog/flopRam.sv ====
`timescale 1ns/1ps
`default_nettype none

// One write port, one read port RAM built from flops
// The read data is registered, giving one cycle of read latency
module flopRam (
  input logic clk,
  input logic rstN,
  ramIf.mem   ram
);

  // Storage array of Depth data words
  logic [mfifoPkg::Width-1:0] mem [ramPkg::Depth];

  // Write and registered read share the same clock edge
  always_ff @(posedge clk) begin
    if (ram.wrValid) begin
      mem[ram.wrAddr] <= ram.wrData;
    end
    // Read data only moves when an address is presented
    if (ram.rdAddrValid) begin
      ram.rdData <= mem[ram.rdAddr];
    end
  end

  // Read data valid follows the address valid by one cycle
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ram.rdDataValid <= 1'b0;
    end else begin
      ram.rdDataValid <= ram.rdAddrValid;
    end
  end

endmodule : flopRam

`default_nettype wire

// ==== verilog/lruArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

// Least-recently-used arbiter
// The order list holds requester IDs, position 0 being the one granted longest ago
module lruArbiter (
  input  logic                           clk,
  input  logic                           rstN,
  input  logic [mfifoPkg::NumFifos-1:0]  request,
  output logic [mfifoPkg::NumFifos-1:0]  grant
);

  logic [mfifoPkg::NumFifos-1:0][mfifoPkg::FifoIdWidth-1:0] order;
  logic                                                     found;
  logic [mfifoPkg::FifoIdWidth-1:0]                         winPos;

  // Walk the order from oldest to newest and stop at the first requester
  always_comb begin
    grant  = '0;
    found  = 1'b0;
    winPos = '0;
    for (int p = 0; p < mfifoPkg::NumFifos; p++) begin
      if (!found && request[order[p]]) begin
        found           = 1'b1;
        winPos          = mfifoPkg::FifoIdWidth'(p);
        grant[order[p]] = 1'b1;
      end
    end
  end

  // The winner moves to the newest slot and everyone behind it shifts up by one
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      // Lower IDs start out as the oldest
      for (int p = 0; p < mfifoPkg::NumFifos; p++) begin
        order[p] <= mfifoPkg::FifoIdWidth'(p);
      end
    end else if (found) begin
      for (int p = 0; p < mfifoPkg::NumFifos - 1; p++) begin
        if (p >= int'(winPos)) begin
          order[p] <= order[p+1];
        end
      end
      order[mfifoPkg::NumFifos-1] <= order[winPos];
    end
  end

endmodule : lruArbiter

`default_nettype wire

// ==== verilog/stagingBuffer.sv ====
`timescale 1ns/1ps
`default_nettype none

// Two-entry pop buffer for one logical FIFO
// A slot is reserved when a RAM read is issued and filled when the data returns
module stagingBuffer (
  input  logic                        clk,
  input  logic                        rstN,
  input  logic                        reserve,
  input  logic                        fillValid,
  input  logic [mfifoPkg::Width-1:0]  fillData,
  input  logic                        popReady,
  output logic                        hasSpace,
  output logic                        popValid,
  output logic [mfifoPkg::Width-1:0]  popData,
  output logic                        empty
);

  logic [mfifoPkg::Width-1:0]          mem [mfifoPkg::StagingDepth];
  // One-bit pointers are enough for a depth of two
  logic                                wrPtr;
  logic                                rdPtr;
  logic [mfifoPkg::StagingCntWidth-1:0] count;
  logic [mfifoPkg::StagingCntWidth-1:0] reserved;
  logic [mfifoPkg::StagingCntWidth:0]   committed;
  logic                                popFire;

  assign popFire = popValid && popReady;
  assign popValid = (count != '0);
  assign empty    = (count == '0);
  assign popData  = mem[rdPtr];

  // Reads in flight count against the space just like stored entries
  assign committed = {1'b0, count} + {1'b0, reserved};
  assign hasSpace  = (committed < mfifoPkg::StagingDepth);

  always_ff @(posedge clk) begin
    if (fillValid) begin
      mem[wrPtr] <= fillData;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wrPtr    <= 1'b0;
      rdPtr    <= 1'b0;
      count    <= '0;
      reserved <= '0;
    end else begin
      if (fillValid) begin
        wrPtr <= ~wrPtr;
      end
      if (popFire) begin
        rdPtr <= ~rdPtr;
      end
      // Fill and pop in the same cycle leave the occupancy unchanged
      case ({fillValid, popFire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Arriving data turns a reservation into an occupied slot
      case ({reserve, fillValid})
        2'b10:   reserved <= reserved + 1'b1;
        2'b01:   reserved <= reserved - 1'b1;
        default: reserved <= reserved;
      endcase
    end
  end

endmodule : stagingBuffer

`default_nettype wire

// ==== verilog/sharedFifoCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

// Controller of the shared multi-FIFO
// Pointers are kept as offsets from each FIFO's base, so an offset of zero is the base
module sharedFifoCtrl (
  input  logic                                                  clk,
  input  logic                                                  rstN,
  input  logic [mfifoPkg::NumFifos-1:0][ramPkg::AddrWidth-1:0] configBase,
  input  logic [mfifoPkg::NumFifos-1:0][ramPkg::AddrWidth-1:0] configBound,
  output logic                                                  configError,
  input  logic                                                  pushValid,
  input  logic [mfifoPkg::Width-1:0]                            pushData,
  input  logic [mfifoPkg::FifoIdWidth-1:0]                      pushFifoId,
  output logic                                                  pushReady,
  output logic [mfifoPkg::NumFifos-1:0]                         pushFull,
  output logic [mfifoPkg::NumFifos-1:0]                         popValid,
  output logic [mfifoPkg::NumFifos-1:0][mfifoPkg::Width-1:0]   popData,
  output logic [mfifoPkg::NumFifos-1:0]                         popEmpty,
  input  logic [mfifoPkg::NumFifos-1:0]                         popReady,
  ramIf.ctrl                                                    ram
);

  logic [ramPkg::AddrWidth-1:0]  wrOff    [mfifoPkg::NumFifos];
  logic [ramPkg::AddrWidth-1:0]  rdOff    [mfifoPkg::NumFifos];
  logic [ramPkg::AddrWidth-1:0]  lastOff  [mfifoPkg::NumFifos];
  logic [ramPkg::CountWidth-1:0] ramCount [mfifoPkg::NumFifos];
  logic [ramPkg::CountWidth-1:0] fifoSize [mfifoPkg::NumFifos];
  logic                          active;
  logic                          pushFire;
  logic [mfifoPkg::NumFifos-1:0] pushSel;
  logic [mfifoPkg::NumFifos-1:0] request;
  logic [mfifoPkg::NumFifos-1:0] grant;
  logic [mfifoPkg::NumFifos-1:0] hasSpace;
  logic [mfifoPkg::NumFifos-1:0] stagingEmpty;
  // One-hot grant delayed to line up with the returning read data
  logic [ramPkg::ReadLatency-1:0][mfifoPkg::NumFifos-1:0] fillPipe;

  // Ranges must be non-empty, ascending, non-overlapping and inside the RAM
  always_comb begin
    configError = 1'b0;
    for (int i = 0; i < mfifoPkg::NumFifos; i++) begin
      if (configBase[i] > configBound[i]) configError = 1'b1;
      if (int'(configBound[i]) >= ramPkg::Depth) configError = 1'b1;
      if (int'(configBase[i]) >= ramPkg::Depth) configError = 1'b1;
      if (i > 0 && configBase[i] <= configBound[i-1]) configError = 1'b1;
      lastOff[i]  = configBound[i] - configBase[i];
      fifoSize[i] = ramPkg::CountWidth'(lastOff[i]) + 1'b1;
      pushFull[i] = (ramCount[i] == fifoSize[i]);
      popEmpty[i] = (ramCount[i] == '0) && stagingEmpty[i];
      // Ask for the read port only with data in RAM and room downstream
      request[i]  = (ramCount[i] != '0) && hasSpace[i];
    end
  end

  // Pushes wait until the first cycle after reset and need a sane config
  assign pushReady = active && !configError && !pushFull[pushFifoId];
  assign pushFire  = pushValid && pushReady;
  assign pushSel   = pushFire ? (mfifoPkg::NumFifos'(1) << pushFifoId) : '0;

  // An accepted push goes straight into the RAM on the same edge
  assign ram.wrValid = pushFire;
  assign ram.wrAddr  = configBase[pushFifoId] + wrOff[pushFifoId];
  assign ram.wrData  = pushData;

  lruArbiter lruArbiter_inst (
    .clk,
    .rstN,
    .request,
    .grant
  );

  // Grant is one-hot, so the read address is an OR of masked per-FIFO addresses
  always_comb begin
    ram.rdAddr = '0;
    for (int i = 0; i < mfifoPkg::NumFifos; i++) begin
      if (grant[i]) ram.rdAddr = ram.rdAddr | (configBase[i] + rdOff[i]);
    end
  end
  assign ram.rdAddrValid = |grant;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      active   <= 1'b0;
      fillPipe <= '0;
      for (int i = 0; i < mfifoPkg::NumFifos; i++) begin
        wrOff[i]    <= '0;
        rdOff[i]    <= '0;
        ramCount[i] <= '0;
      end
    end else begin
      active      <= 1'b1;
      fillPipe[0] <= grant;
      for (int k = 1; k < ramPkg::ReadLatency; k++) begin
        fillPipe[k] <= fillPipe[k-1];
      end
      for (int i = 0; i < mfifoPkg::NumFifos; i++) begin
        // Offsets wrap at the bound, bringing the address back to the base
        if (pushSel[i]) wrOff[i] <= (wrOff[i] == lastOff[i]) ? '0 : wrOff[i] + 1'b1;
        if (grant[i]) rdOff[i] <= (rdOff[i] == lastOff[i]) ? '0 : rdOff[i] + 1'b1;
        // The RAM slot is freed as soon as its read is issued
        case ({pushSel[i], grant[i]})
          2'b10:   ramCount[i] <= ramCount[i] + 1'b1;
          2'b01:   ramCount[i] <= ramCount[i] - 1'b1;
          default: ramCount[i] <= ramCount[i];
        endcase
      end
    end
  end

  for (genvar i = 0; i < mfifoPkg::NumFifos; i++) begin : gStage
    stagingBuffer stagingBuffer_inst (
      .clk,
      .rstN,
      .reserve   (grant[i]),
      .fillValid (ram.rdDataValid && fillPipe[ramPkg::ReadLatency-1][i]),
      .fillData  (ram.rdData),
      .popReady  (popReady[i]),
      .hasSpace  (hasSpace[i]),
      .popValid  (popValid[i]),
      .popData   (popData[i]),
      .empty     (stagingEmpty[i])
    );
  end

endmodule : sharedFifoCtrl

`default_nettype wire

// ==== verilog/sharedFifoFlops.sv ====
`timescale 1ns/1ps
`default_nettype none

// Shared-storage multi-FIFO with flop-based storage and pseudo-static allocation
// Base and bound inputs are inclusive and must be held stable while out of reset
module sharedFifoFlops (
  input  logic                                                  clk,
  input  logic                                                  rstN,
  input  logic [mfifoPkg::NumFifos-1:0][ramPkg::AddrWidth-1:0] configBase,
  input  logic [mfifoPkg::NumFifos-1:0][ramPkg::AddrWidth-1:0] configBound,
  output logic                                                  configError,
  input  logic                                                  pushValid,
  input  logic [mfifoPkg::Width-1:0]                            pushData,
  input  logic [mfifoPkg::FifoIdWidth-1:0]                      pushFifoId,
  output logic                                                  pushReady,
  output logic [mfifoPkg::NumFifos-1:0]                         pushFull,
  output logic [mfifoPkg::NumFifos-1:0]                         popValid,
  output logic [mfifoPkg::NumFifos-1:0][mfifoPkg::Width-1:0]   popData,
  output logic [mfifoPkg::NumFifos-1:0]                         popEmpty,
  input  logic [mfifoPkg::NumFifos-1:0]                         popReady
);

  // Bundle between the controller and the data RAM
  ramIf ramBus ();

  sharedFifoCtrl sharedFifoCtrl_inst (
    .clk,
    .rstN,
    .configBase,
    .configBound,
    .configError,
    .pushValid,
    .pushData,
    .pushFifoId,
    .pushReady,
    .pushFull,
    .popValid,
    .popData,
    .popEmpty,
    .popReady,
    .ram (ramBus.ctrl)
  );

  flopRam flopRam_inst (
    .clk,
    .rstN,
    .ram (ramBus.mem)
  );

endmodule : sharedFifoFlops

`default_nettype wire

// ==== verif/sharedFifo_props.sv ====
`timescale 1ns/1ps
`default_nettype none

// Protocol and state checks on the shared FIFO controller
module sharedFifoProps (
  input logic                           clk,
  input logic                           rstN,
  input logic                           configError,
  input logic [mfifoPkg::NumFifos-1:0]  grant,
  input logic [mfifoPkg::NumFifos-1:0]  popValid,
  input logic [ramPkg::CountWidth-1:0]  ramCount [mfifoPkg::NumFifos],
  input logic [ramPkg::CountWidth-1:0]  fifoSize [mfifoPkg::NumFifos]
);

  // The read port serves at most one FIFO per cycle
  grantOneHot: assert property (@(posedge clk) disable iff (!rstN) $onehot0(grant))
    else $error("arbiter grant is not one-hot");

  for (genvar i = 0; i < mfifoPkg::NumFifos; i++) begin : gFifo
    // A bad configuration never lets a word into the RAM
    noDataOnBadConfig: assert property (@(posedge clk) disable iff (!rstN)
      configError |-> ramCount[i] == '0)
      else $error("FIFO %0d holds data under a bad configuration", i);

    // Sizes mean nothing under a bad configuration, so only check a sane one
    countInRange: assert property (@(posedge clk) disable iff (!rstN)
      !configError |-> ramCount[i] <= fifoSize[i])
      else $error("RAM count of FIFO %0d exceeds its size", i);

    // A pop port only turns valid once a granted read has returned its word
    popOnlyWithData: assert property (@(posedge clk) disable iff (!rstN)
      $rose(popValid[i]) |-> $past(grant[i], ramPkg::ReadLatency + 1))
      else $error("popValid rose on FIFO %0d without a returned read", i);
  end

endmodule : sharedFifoProps

bind sharedFifoCtrl sharedFifoProps sharedFifoProps_inst (
  .clk,
  .rstN,
  .configError,
  .grant,
  .popValid,
  .ramCount,
  .fifoSize
);

`default_nettype wire

// ==== verif/tbSharedFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

// Testbench for the shared multi-FIFO, driven record by record from a pattern file
// A config record resets the DUT, push records feed it and a fill record back-pressures one FIFO
module tbSharedFifo;

  localparam int MaxRecords = 64;
  localparam int ClkPeriod = 10;
  localparam int CyclesPerRecord = 50;
  localparam int AllOnes = (1 << mfifoPkg::NumFifos) - 1;

  logic                                                  clk;
  logic                                                  rstN;
  logic [mfifoPkg::NumFifos-1:0][ramPkg::AddrWidth-1:0]  configBase;
  logic [mfifoPkg::NumFifos-1:0][ramPkg::AddrWidth-1:0]  configBound;
  logic                                                  configError;
  logic                                                  pushValid;
  logic [mfifoPkg::Width-1:0]                            pushData;
  logic [mfifoPkg::FifoIdWidth-1:0]                      pushFifoId;
  logic                                                  pushReady;
  logic [mfifoPkg::NumFifos-1:0]                         pushFull;
  logic [mfifoPkg::NumFifos-1:0]                         popValid;
  logic [mfifoPkg::NumFifos-1:0][mfifoPkg::Width-1:0]    popData;
  logic [mfifoPkg::NumFifos-1:0]                         popEmpty;
  logic [mfifoPkg::NumFifos-1:0]                         popReady;

  logic [39:0]                 patterns [MaxRecords];
  // Reference model, one queue of expected words per logical FIFO
  logic [mfifoPkg::Width-1:0]  modelQ [mfifoPkg::NumFifos][$];
  // FIFOs whose pop side is held off
  logic [mfifoPkg::NumFifos-1:0] holdMask;
  int                          recordCount;

  sharedFifoFlops sharedFifoFlops_inst (
    .clk,
    .rstN,
    .configBase,
    .configBound,
    .configError,
    .pushValid,
    .pushData,
    .pushFifoId,
    .pushReady,
    .pushFull,
    .popValid,
    .popData,
    .popEmpty,
    .popReady
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  task automatic checkEqual(input int actual, input int expected, input string what);
    if (actual != expected) begin
      $display("[FAIL] %0t ns: %s, expected 0x%0h, got 0x%0h", $time, what, expected, actual);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  task automatic failRun(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    $display("tests failed");
    $fatal(1);
  endtask

  // Random pop side, with held FIFOs masked off
  initial begin
    popReady = '0;
    forever begin
      @(posedge clk);
      #1;
      popReady = mfifoPkg::NumFifos'($urandom) & ~holdMask;
    end
  end

  // Handshakes are sampled at the falling edge, where every signal has settled
  always @(negedge clk) begin
    if (rstN) begin
      for (int i = 0; i < mfifoPkg::NumFifos; i++) begin
        if (popValid[i] && popReady[i]) begin
          if (modelQ[i].size() == 0) begin
            failRun($sformatf("FIFO %0d delivered a word that was never pushed", i));
          end else begin
            checkEqual(int'(popData[i]), int'(modelQ[i][0]), $sformatf("FIFO %0d pop data", i));
            void'(modelQ[i].pop_front());
          end
        end
      end
      if (pushValid && pushReady) begin
        modelQ[pushFifoId].push_back(pushData);
      end
    end
  end

  // Tasks below start and end 1 ns after a rising edge
  task automatic applyConfig(input logic [39:0] word);
    logic expectError;
    expectError = word[32];
    @(posedge clk);
    #1;
    rstN        = 1'b0;
    pushValid   = 1'b0;
    holdMask    = '0;
    configBase  = word[31:16];
    configBound = word[15:0];
    @(negedge clk);
    checkEqual(int'(pushReady), 0, "pushReady during reset");
    repeat (5) @(posedge clk);
    #1;
    rstN = 1'b1;
    @(negedge clk);
    checkEqual(int'(popValid), 0, "popValid after reset");
    checkEqual(int'(popEmpty), AllOnes, "popEmpty after reset");
    checkEqual(int'(pushFull), 0, "pushFull after reset");
    checkEqual(int'(configError), int'(expectError), "configError");
    @(posedge clk);
    #1;
    // A bad configuration must refuse a waiting push to every FIFO
    if (expectError) begin
      pushValid = 1'b1;
      for (int id = 0; id < mfifoPkg::NumFifos; id++) begin
        pushFifoId = mfifoPkg::FifoIdWidth'(id);
        @(negedge clk);
        checkEqual(int'(pushReady), 0, "pushReady under bad config");
        @(posedge clk);
        #1;
      end
      pushValid = 1'b0;
    end
  endtask

  task automatic pushWord(input logic [1:0] id, input logic [7:0] data);
    logic accepted;
    pushFifoId = id;
    pushData   = data;
    pushValid  = 1'b1;
    accepted   = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = pushReady;
      @(posedge clk);
      #1;
    end
    pushValid = 1'b0;
  endtask

  // Hold one FIFO's pop side and push until its ready stays low
  task automatic fillUntilFull(input logic [1:0] id, input int expected);
    int accepted;
    int lowRun;
    // Start from an empty FIFO so the count covers the whole capacity
    while (modelQ[id].size() != 0) begin
      @(posedge clk);
      #1;
    end
    holdMask   = mfifoPkg::NumFifos'(1) << id;
    accepted   = 0;
    lowRun     = 0;
    pushFifoId = id;
    pushData   = mfifoPkg::Width'($urandom);
    pushValid  = 1'b1;
    // Ready dips while a read of the held FIFO waits up to NumFifos cycles for the arbiter
    // Only a longer low run means the FIFO is really full
    while (lowRun <= mfifoPkg::NumFifos) begin
      @(negedge clk);
      if (pushReady) begin
        accepted++;
        lowRun = 0;
      end else begin
        lowRun++;
      end
      @(posedge clk);
      #1;
      pushData = mfifoPkg::Width'($urandom);
    end
    pushValid = 1'b0;
    checkEqual(accepted, expected, $sformatf("pushes accepted by full FIFO %0d", id));
    @(negedge clk);
    checkEqual(int'(pushFull[id]), 1, "pushFull on the held FIFO");
    checkEqual(int'(pushReady), 0, "pushReady on the held FIFO");
    @(posedge clk);
    #1;
  endtask

  task automatic drainAll();
    int stable;
    holdMask  = '0;
    pushValid = 1'b0;
    stable    = 0;
    // A read in flight shows as empty for one cycle, so require a short run
    while (stable < 3) begin
      @(negedge clk);
      if (popEmpty == AllOnes) stable++;
      else stable = 0;
    end
    @(posedge clk);
    #1;
    for (int i = 0; i < mfifoPkg::NumFifos; i++) begin
      checkEqual(modelQ[i].size(), 0, $sformatf("model queue %0d after drain", i));
    end
  endtask

  // Watchdog sized from the number of records in the pattern file
  initial begin
    wait (recordCount > 0);
    repeat ((recordCount + 4) * CyclesPerRecord) @(posedge clk);
    $display("Error: watchdog expired, the DUT stopped making progress");
    $display("tests failed");
    $fatal(1);
  end

  initial begin
    int          rec;
    int          leftover;
    logic        started;
    logic [39:0] word;
    void'($urandom(4667));
    rstN        = 1'b0;
    configBase  = '0;
    configBound = '0;
    pushValid   = 1'b0;
    pushData    = '0;
    pushFifoId  = '0;
    holdMask    = '0;
    started     = 1'b0;
    $readmemh("verif/sharedFifoPatterns.txt", patterns);
    rec = 0;
    while (rec < MaxRecords && patterns[rec][39:36] != 4'h0) rec++;
    recordCount = rec;
    if (recordCount == 0 || patterns[0][39:36] != 4'h1) begin
      failRun("pattern file must start with a config record");
    end
    for (rec = 0; rec < recordCount; rec++) begin
      word = patterns[rec];
      case (word[39:36])
        4'h1: begin
          if (started) drainAll();
          applyConfig(word);
          started = 1'b1;
        end
        4'h2: pushWord(word[9:8], word[7:0]);
        4'h3: fillUntilFull(word[9:8], int'(word[7:0]));
        default: failRun($sformatf("unknown record type in pattern line %0d", rec));
      endcase
    end
    drainAll();
    leftover = 0;
    for (int i = 0; i < mfifoPkg::NumFifos; i++) begin
      leftover += modelQ[i].size();
    end
    if (leftover == 0 && popEmpty == AllOnes) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("Error: data left in the FIFOs after the final drain");
      $display("tests failed");
      $fatal(1);
    end
  end

endmodule : tbSharedFifo

`default_nettype wire

// ==== verif/sharedFifoPatterns.txt ====
// Top nibble is the record type. 1 = config: expected configError, bases b3..b0, bounds d3..d0
// 2 = push: FIFO ID in bits 9:8, data in 7:0. 3 = fill: FIFO ID in 9:8, expected count in 7:0
10C840FB73
2000000011
2000000122
2000000233
2000000344
2000000055
2000000166
2000000077
2000000388
3000000206
20000001A1
20000000B2
20000003C3
20000001D4
11C860FB53
11C740FB73
10A710F960
3000000003
20000001E5
20000002F6
2000000307
2000000118
2000000229
0000000000

// ==== tb.f ====
verilog/mfifoPkg.sv
verilog/ramPkg.sv
verilog/ramIf.sv
verilog/flopRam.sv
verilog/lruArbiter.sv
verilog/stagingBuffer.sv
verilog/sharedFifoCtrl.sv
verilog/sharedFifoFlops.sv
verif/sharedFifo_props.sv
verif/tbSharedFifo.sv

// ==== runSim.sh ====
#!/bin/sh
# Build and run the shared multi-FIFO testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tbSharedFifo -f tb.f
# The run status is not checked here, the log decides the result
./obj_dir/VtbSharedFifo 2>&1 | tee sim.log
if grep -q "tests failed" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
if ! grep -q "all tests passed" sim.log; then
  echo "Simulation ended without a pass report, see sim.log"
  exit 1
fi
echo "Simulation passed"
